//--- sim.f
src/fifo_show_pkg.sv
src/key_pulse.sv
src/tick_gen.sv
src/pattern_source.sv
src/debug_fifo.sv
src/digit_scanner.sv
src/fifo_show_top.sv
sim/tb_fifo_show.sv

//--- sim/tb_fifo_show.sv
// assumes a 4-cycle key-to-LED latency and SCAN_DIV cycles per digit; the run ends at a cycle limit
`timescale 1ns/1ps

module tb_fifo_show
  import fifo_show_pkg::*;
;

  // ----------------------------------------------------------
  // run length and stimulus constants
  // ----------------------------------------------------------

  localparam int          RESET_CYCLES   = 4;
  localparam int          PRESS_CYCLES   = 6;
  localparam int          RANDOM_PRESSES = 60;
  // 3 + 8 + 9 + 2 directed presses, then the random mix
  localparam int          NUM_PRESSES    = 22 + RANDOM_PRESSES;
  localparam int          CYCLE_LIMIT    = NUM_PRESSES * PRESS_CYCLES + RESET_CYCLES + 200;
  localparam int          SCAN_CYCLES    = FIFO_DEPTH * SCAN_DIV;
  localparam logic [31:0] LFSR_SEED      = 32'he7c3;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
  localparam int          PUSH_KEY       = 1;
  localparam int          POP_KEY        = 0;

  logic                  clk;
  logic                  rst_n;
  logic [KEY_W-1:0]      key;
  logic [LED_W-1:0]      led;
  logic [SEG_W-1:0]      abcdefgh;
  logic [FIFO_DEPTH-1:0] digit;

  // reference model, circular buffer with valid bits
  logic [DATA_W-1:0]     m_data [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] m_valid;
  int                    m_wr;
  int                    m_rd;
  int                    m_count;
  int                    m_idx;
  logic [LED_W-1:0]      exp_led;
  logic [SEG_W-1:0]      exp_seg;

  // digit select as seen on the previous edge, and how long it has been lit
  logic [FIFO_DEPTH-1:0] digit_last;
  int                    digit_age;
  logic                  digit_stepped;

  string                 test_name;
  int                    errors;
  int                    errors_at_start;
  int                    tests_run;
  int                    tests_failed;
  int                    cycles = 0;
  logic [31:0]           lfsr;

  fifo_show_top u_fifo_show_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .key      (key),
    .led      (led),
    .abcdefgh (abcdefgh),
    .digit    (digit)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // model outputs and assertions
  // ----------------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ LFSR_TAPS;
    else
      return state >> 1;
  endfunction

  function automatic int onehot_index(input logic [FIFO_DEPTH-1:0] sel);
    int idx;
    int p;
    idx = 0;
    for (p = 0; p < FIFO_DEPTH; p++)
      if (sel[p])
        idx = p;
    return idx;
  endfunction

  // next digit position up, top position wraps to 0
  function automatic logic [FIFO_DEPTH-1:0] digit_after(input logic [FIFO_DEPTH-1:0] sel);
    return {sel[FIFO_DEPTH-2:0], sel[FIFO_DEPTH-1]};
  endfunction

  // head comes from storage even when empty, so stale data stays visible
  assign exp_led = {m_count == FIFO_DEPTH, m_count == 0, m_data[m_rd]};

  // position d shows slot FIFO_DEPTH-1-d
  always_comb
  begin
    int slot;
    slot = FIFO_DEPTH - 1 - onehot_index(digit);
    if (m_valid[slot])
      exp_seg = SEG_CODE[m_data[slot]];
    else
      exp_seg = SEG_EMPTY;
  end

  led_matches_model: assert property (@(posedge clk) disable iff (!rst_n) led == exp_led)
  else
  begin
    errors++;
    $display("FAILED %s: led expected %h actual %h", test_name, $sampled(exp_led),
             $sampled(led));
  end

  seg_matches_model: assert property (@(posedge clk) disable iff (!rst_n) abcdefgh == exp_seg)
  else
  begin
    errors++;
    $display("FAILED %s: abcdefgh expected %h actual %h", test_name, $sampled(exp_seg),
             $sampled(abcdefgh));
  end

  // each change moves one position up, after SCAN_DIV cycles on the old digit
  always @(posedge clk)
  begin
    digit_last <= digit;
    if (!rst_n)
    begin
      digit_age     <= 0;
      digit_stepped <= 1'b0;
    end
    else if (digit == digit_last)
      digit_age <= digit_age + 1;
    else
    begin
      digit_age     <= 0;
      digit_stepped <= 1'b1;
      digit_steps_up: assert (digit == digit_after(digit_last))
      else
      begin
        errors++;
        $display("FAILED %s: digit expected %b actual %b", test_name,
                 digit_after(digit_last), digit);
      end
      // first digit after reset also spans the reset release
      digit_dwell: assert (!digit_stepped || digit_age == SCAN_DIV - 1)
      else
      begin
        errors++;
        $display("%s: digit stayed lit for %0d cycles instead of %0d", test_name,
                 digit_age + 1, SCAN_DIV);
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus and check tasks
  // ----------------------------------------------------------

  task automatic model_apply(input int key_bit);
    if (key_bit == PUSH_KEY)
    begin
      // push on a full FIFO is dropped and the index holds
      if (m_count < FIFO_DEPTH)
      begin
        m_data[m_wr]  = PATTERN[m_idx];
        m_valid[m_wr] = 1'b1;
        m_wr          = (m_wr + 1) % FIFO_DEPTH;
        m_idx         = (m_idx + 1) % PATTERN_LEN;
        m_count++;
      end
    end
    else if (m_count > 0)
    begin
      m_valid[m_rd] = 1'b0;
      m_rd          = (m_rd + 1) % FIFO_DEPTH;
      m_count--;
    end
  endtask

  // key high for hold cycles, then low for 4; model moves 4 edges after the rise
  task automatic press(input int key_bit, input int hold);
    int c;
    @(posedge clk);
    key[key_bit] <= 1'b1;
    for (c = 1; c < hold + 4; c++)
    begin
      @(posedge clk);
      if (c == hold)
        key[key_bit] <= 1'b0;
      if (c == 4)
        model_apply(key_bit);
    end
  endtask

  task automatic check_value(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual == expected)
    else
    begin
      errors++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // one full pass over all digits, sampled away from the clock edge
  task automatic scan_display(input logic [FIFO_DEPTH-1:0][SEG_W-1:0] exp_by_pos);
    logic [FIFO_DEPTH-1:0] seen;
    int                    pos;
    seen = '0;
    repeat (SCAN_CYCLES)
    begin
      @(negedge clk);
      pos       = onehot_index(digit);
      seen[pos] = 1'b1;
      check_value("segments", exp_by_pos[pos], abcdefgh);
    end
    if (seen != '1)
    begin
      errors++;
      $display("%s: scan did not visit every digit, seen %b", test_name, seen);
    end
  endtask

  task automatic check_slot(input int slot, input logic [SEG_W-1:0] expected);
    int tries;
    tries = 0;
    @(negedge clk);
    while (!digit[FIFO_DEPTH - 1 - slot] && tries < SCAN_CYCLES)
    begin
      @(negedge clk);
      tries++;
    end
    if (digit[FIFO_DEPTH - 1 - slot])
      check_value("slot segments", expected, abcdefgh);
    else
    begin
      errors++;
      $display("%s: digit for slot %0d was never selected", test_name, slot);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start)
      $display("PASS %s", test_name);
    else
    begin
      tests_failed++;
      $display("FAILED %s: %0d mismatches", test_name, errors - errors_at_start);
    end
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------

  initial
  begin
    logic [FIFO_DEPTH-1:0][SEG_W-1:0] exp_by_pos;
    logic [LED_W-1:0]                 led_before;
    int                               i;
    rst_n        = 1'b0;
    key          = '0;
    lfsr         = LFSR_SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    m_valid      = '0;
    m_wr         = 0;
    m_rd         = 0;
    m_count      = 0;
    m_idx        = 0;
    for (i = 0; i < FIFO_DEPTH; i++)
      m_data[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset");
    @(negedge clk);
    check_value("empty flag", 1, led[4]);
    check_value("full flag", 0, led[5]);
    // scan starts on position 0
    check_value("digit select", 8'h01, digit);
    for (i = 0; i < FIFO_DEPTH; i++)
      exp_by_pos[i] = SEG_EMPTY;
    scan_display(exp_by_pos);
    end_test();

    start_test("push sequence");
    for (i = 0; i < 3; i++)
    begin
      press(PUSH_KEY, 2);
      @(negedge clk);
      check_value("head", PATTERN[0], led[3:0]);
    end
    // oldest entry on the leftmost digit
    for (i = 0; i < FIFO_DEPTH; i++)
      exp_by_pos[i] = (i >= FIFO_DEPTH - 3) ? SEG_CODE[PATTERN[FIFO_DEPTH - 1 - i]] : SEG_EMPTY;
    scan_display(exp_by_pos);
    end_test();

    start_test("fill and overflow");
    repeat (FIFO_DEPTH - 3) press(PUSH_KEY, 2);
    @(negedge clk);
    check_value("full flag", 1, led[5]);
    led_before = led;
    press(PUSH_KEY, 2);
    @(negedge clk);
    check_value("leds after push on full", led_before, led);
    press(POP_KEY, 2);
    press(PUSH_KEY, 2);
    @(negedge clk);
    check_value("head", PATTERN[1], led[3:0]);
    // write pointer has wrapped, dropped push must not have used up PATTERN[8]
    check_slot(0, SEG_CODE[PATTERN[FIFO_DEPTH]]);
    end_test();

    start_test("drain and underflow");
    for (i = 1; i <= FIFO_DEPTH; i++)
    begin
      @(negedge clk);
      check_value("head", PATTERN[i], led[3:0]);
      press(POP_KEY, 2);
    end
    @(negedge clk);
    check_value("empty flag", 1, led[4]);
    led_before = led;
    press(POP_KEY, 2);
    @(negedge clk);
    check_value("leds after pop on empty", led_before, led);
    end_test();

    start_test("held key");
    press(PUSH_KEY, 20);
    @(negedge clk);
    check_value("head", PATTERN[FIFO_DEPTH + 1], led[3:0]);
    // a single pop empties it only if one push got in
    press(POP_KEY, 2);
    @(negedge clk);
    check_value("empty flag after one pop", 1, led[4]);
    end_test();

    start_test("random mix");
    repeat (RANDOM_PRESSES)
    begin
      lfsr = lfsr_next(lfsr);
      press(lfsr[0] ? PUSH_KEY : POP_KEY, 2);
    end
    @(negedge clk);
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- src/debug_fifo.sv
// FIFO_DEPTH is any size >= 2; a push while full is dropped even if a pop comes in the same cycle
`timescale 1ns/1ps

module debug_fifo
  import fifo_show_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              push,
  input  logic                              pop,
  input  logic [DATA_W-1:0]                 write_data,
  output logic [DATA_W-1:0]                 read_data,
  output logic                              empty,
  output logic                              full,
  output logic [FIFO_DEPTH-1:0]             debug_valid,
  output logic [FIFO_DEPTH-1:0][DATA_W-1:0] debug_data
);

  // ----------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------

  logic [FIFO_DEPTH-1:0][DATA_W-1:0] slot_data;
  // one bit per physical slot
  logic [FIFO_DEPTH-1:0]             slot_valid;
  logic [PTR_W-1:0]                  wr_ptr;
  logic [PTR_W-1:0]                  rd_ptr;
  logic                              do_push;
  logic                              do_pop;

  // pointer step with wrap at FIFO_DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // flags
  // ----------------------------------------------------------

  // valid bits replace an occupancy counter
  assign empty   = ~|slot_valid;
  assign full    = &slot_valid;

  // requests that would overflow or underflow are dropped here
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // ----------------------------------------------------------
  // control state
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr             <= ptr_next(wr_ptr);
        slot_valid[wr_ptr] <= 1'b1;
      end
      // with both active the pointers differ, so the two bits never collide
      if (do_pop)
      begin
        rd_ptr             <= ptr_next(rd_ptr);
        slot_valid[rd_ptr] <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // data slots
  // ----------------------------------------------------------

  // cleared so the LEDs and digits start from a known value
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      slot_data <= '0;
    else if (do_push)
      slot_data[wr_ptr] <= write_data;
  end

  // head straight from storage, no output register
  assign read_data   = slot_data[rd_ptr];

  // whole contents exposed for the display
  assign debug_valid = slot_valid;
  assign debug_data  = slot_data;

endmodule

//--- src/digit_scanner.sv
// one digit is lit at a time, refresh rate is clk / (SCAN_DIV * FIFO_DEPTH)
`timescale 1ns/1ps

module digit_scanner
  import fifo_show_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              scan_tick,
  input  logic [FIFO_DEPTH-1:0]             debug_valid,
  input  logic [FIFO_DEPTH-1:0][DATA_W-1:0] debug_data,
  output logic [SEG_W-1:0]                  abcdefgh,
  output logic [FIFO_DEPTH-1:0]             digit
);

  // ----------------------------------------------------------
  // scan position
  // ----------------------------------------------------------

  // display position, 0 is the rightmost digit
  logic [PTR_W-1:0]  scan_pos;
  // physical FIFO slot shown at scan_pos
  logic [PTR_W-1:0]  scan_slot;
  logic              scan_valid;
  logic [DATA_W-1:0] scan_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      scan_pos <= '0;
    end
    else if (scan_tick)
    begin
      if (scan_pos == PTR_W'(FIFO_DEPTH - 1))
        scan_pos <= '0;
      else
        scan_pos <= scan_pos + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // digit select
  // ----------------------------------------------------------

  // one-hot, active high anode enable
  always_comb
  begin
    digit           = '0;
    digit[scan_pos] = 1'b1;
  end

  // ----------------------------------------------------------
  // slot mirroring
  // ----------------------------------------------------------

  // slot 0 lands on the leftmost digit, so the FIFO reads left to right
  assign scan_slot  = PTR_W'(FIFO_DEPTH - 1) - scan_pos;

  assign scan_valid = debug_valid[scan_slot];
  assign scan_data  = debug_data[scan_slot];

  // ----------------------------------------------------------
  // segment decode
  // ----------------------------------------------------------

  // unused slot shows a bar instead of a stale digit
  always_comb
  begin
    if (scan_valid)
      abcdefgh = SEG_CODE[scan_data];
    else
      abcdefgh = SEG_EMPTY;
  end

endmodule

//--- src/fifo_show_pkg.sv
// SCAN_DIV is small for short simulations and must be raised for a readable scan on a board
package fifo_show_pkg;

  // ----------------------------------------------------------
  // widths and depths
  // ----------------------------------------------------------

  // one FIFO entry is a single hex digit
  localparam int DATA_W      = 4;
  // FIFO slots, also the number of display digits
  localparam int FIFO_DEPTH  = 8;
  localparam int PTR_W       = $clog2(FIFO_DEPTH);
  // key[1] pushes, key[0] pops
  localparam int KEY_W       = 2;
  // head value plus empty and full flags
  localparam int LED_W       = 6;
  // abcdefgh, segment a in the msb, dot in the lsb
  localparam int SEG_W       = 8;

  // ----------------------------------------------------------
  // display scan strobe
  // ----------------------------------------------------------

  localparam int SCAN_DIV    = 4;
  localparam int SCAN_CNT_W  = $clog2(SCAN_DIV);

  // ----------------------------------------------------------
  // push sequence and segment codes
  // ----------------------------------------------------------

  localparam int PATTERN_LEN = 16;
  localparam int PAT_IDX_W   = $clog2(PATTERN_LEN);

  // fixed permutation of all 16 codes
  localparam logic [DATA_W-1:0] PATTERN [0:PATTERN_LEN-1] = '{
    4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
    4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
  };

  // hex digit to abcdefgh, active high, dot off
  localparam logic [SEG_W-1:0] SEG_CODE [0:15] = '{
    8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
    8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
  };

  // only the middle bar lit
  localparam logic [SEG_W-1:0] SEG_EMPTY = 8'b0000_0010;

endpackage

//--- src/fifo_show_top.sv
// single clock design, keys are raw inputs and each press counts as one request
`timescale 1ns/1ps

module fifo_show_top
  import fifo_show_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [KEY_W-1:0]      key,
  output logic [LED_W-1:0]      led,
  output logic [SEG_W-1:0]      abcdefgh,
  output logic [FIFO_DEPTH-1:0] digit
);

  logic                              push;
  logic                              pop;
  logic                              push_accepted;
  logic                              scan_tick;
  logic [DATA_W-1:0]                 write_data;
  logic [DATA_W-1:0]                 read_data;
  logic                              empty;
  logic                              full;
  logic [FIFO_DEPTH-1:0]             debug_valid;
  logic [FIFO_DEPTH-1:0][DATA_W-1:0] debug_data;

  // ----------------------------------------------------------
  // key requests
  // ----------------------------------------------------------

  key_pulse u_key_pulse (
    .clk   (clk),
    .rst_n (rst_n),
    .key   (key),
    .push  (push),
    .pop   (pop)
  );

  // same condition the FIFO uses to take a push
  assign push_accepted = push & ~full;

  // ----------------------------------------------------------
  // data path
  // ----------------------------------------------------------

  pattern_source u_pattern_source (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_accepted (push_accepted),
    .write_data    (write_data)
  );

  debug_fifo u_debug_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (push),
    .pop         (pop),
    .write_data  (write_data),
    .read_data   (read_data),
    .empty       (empty),
    .full        (full),
    .debug_valid (debug_valid),
    .debug_data  (debug_data)
  );

  // ----------------------------------------------------------
  // display and LEDs
  // ----------------------------------------------------------

  tick_gen u_tick_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .scan_tick (scan_tick)
  );

  digit_scanner u_digit_scanner (
    .clk         (clk),
    .rst_n       (rst_n),
    .scan_tick   (scan_tick),
    .debug_valid (debug_valid),
    .debug_data  (debug_data),
    .abcdefgh    (abcdefgh),
    .digit       (digit)
  );

  // full in the top bit, then empty, then the head value
  assign led = {full, empty, read_data};

endmodule

//--- src/key_pulse.sv
// no debouncing is done, so a bouncing mechanical key can give several requests per press
`timescale 1ns/1ps

module key_pulse
  import fifo_show_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [KEY_W-1:0] key,
  output logic             push,
  output logic             pop
);

  // ----------------------------------------------------------
  // two-flop synchroniser per key
  // ----------------------------------------------------------

  logic [KEY_W-1:0] key_meta;
  logic [KEY_W-1:0] key_sync;
  // last synchronised value, for rise detection
  logic [KEY_W-1:0] key_hist;
  // registered one-cycle pulses, bit order as key
  logic [KEY_W-1:0] key_rise;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_hist <= '0;
      key_rise <= '0;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
      key_hist <= key_sync;
      // high only in the cycle after the synchronised key goes up
      key_rise <= key_sync & ~key_hist;
    end
  end

  // a held key gives one pulse, since the history catches up next cycle
  assign push = key_rise[1];
  assign pop  = key_rise[0];

endmodule

//--- src/pattern_source.sv
// the index only moves on pushes the FIFO really takes, so a push on a full FIFO skips nothing
`timescale 1ns/1ps

module pattern_source
  import fifo_show_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_accepted,
  output logic [DATA_W-1:0] write_data
);

  // ----------------------------------------------------------
  // write index
  // ----------------------------------------------------------

  logic [PAT_IDX_W-1:0] pat_idx;
  logic                 pat_last;

  // last table entry, next step goes back to 0
  assign pat_last = (pat_idx == PAT_IDX_W'(PATTERN_LEN - 1));

  // steps on the same edge that stores the current value
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pat_idx <= '0;
    end
    else if (push_accepted)
    begin
      if (pat_last)
        pat_idx <= '0;
      else
        pat_idx <= pat_idx + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // table lookup
  // ----------------------------------------------------------

  // value for the next push, ready one cycle after the previous one
  assign write_data = PATTERN[pat_idx];

endmodule

//--- src/tick_gen.sv
// SCAN_DIV must be at least 2, the strobe comes one cycle after terminal count
`timescale 1ns/1ps

module tick_gen
  import fifo_show_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  output logic scan_tick
);

  logic [SCAN_CNT_W-1:0] div_cnt;
  logic                  at_terminal;

  assign at_terminal = (div_cnt == SCAN_CNT_W'(SCAN_DIV - 1));

  // free running divider, strobe is a clock enable and not a clock
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt   <= '0;
      scan_tick <= 1'b0;
    end
    else
    begin
      scan_tick <= at_terminal;
      if (at_terminal)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule
